// File: source/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// Address geometry
`define TLB_VPN_W      20
`define TLB_PTAG_W     22
`define TLB_META_W     8

// Number of sets is 2**TLB_ENTRIES_W
`define TLB_ENTRIES_W  4

// Associativity, 2 or more
`define TLB_WAYS       3
`define TLB_WAY_W      $clog2(`TLB_WAYS)

// Command encodings on request.cmd
`define TLB_CMD_NONE            2'd0
`define TLB_CMD_RESOLVE         2'd1
`define TLB_CMD_NEW_ENTRY       2'd2
`define TLB_CMD_INVALIDATE_ALL  2'd3

`endif

// File: source/tlb_pkg.sv
`include "tlb_defs.svh"

package tlb_pkg;

    typedef logic [`TLB_VPN_W-1:0]                vpn_t;
    typedef logic [`TLB_ENTRIES_W-1:0]            set_index_t;   // Low part of the VPN
    typedef logic [`TLB_VPN_W-`TLB_ENTRIES_W-1:0] vtag_t;        // High part of the VPN
    typedef logic [`TLB_PTAG_W-1:0]               ptag_t;
    typedef logic [`TLB_META_W-1:0]               metadata_t;    // Bit 0 is valid
    typedef logic [`TLB_META_W-1:1]               metadata_hi_t;
    typedef logic [`TLB_WAY_W-1:0]                way_index_t;
    typedef logic [1:0]                           tlb_cmd_t;

    typedef struct packed {
        tlb_cmd_t  cmd;
        vpn_t      vpn;
        metadata_t new_metadata;
        ptag_t     new_ptag;
    } tlb_request_t;

    // Payload as read back from one way
    typedef struct packed {
        vtag_t        vtag;
        ptag_t        ptag;
        metadata_hi_t meta_hi;
    } tlb_way_read_t;

    typedef struct packed {
        logic       hit;
        way_index_t way;
        metadata_t  metadata;
        ptag_t      ptag;
    } tlb_result_t;

endpackage

// File: source/tlb_mem_1rw.sv
module tlb_mem_1rw #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] address,
    input  logic                     read,
    input  logic                     write,
    input  logic [WIDTH-1:0]         writedata,
    output logic [WIDTH-1:0]         readdata
);

    logic [WIDTH-1:0] storage [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            storage[address] <= writedata;
        end
        if (read) begin
            readdata <= storage[address]; // Held until the next read
        end
    end

    // Single port, the controller never issues both in one cycle
    read_write_exclusive: assert property (
        @(posedge clk) !(read && write)
    );

endmodule

// File: source/tlb_way_store.sv
`include "tlb_defs.svh"

module tlb_way_store (
    input  logic                   clk,
    input  tlb_pkg::set_index_t    address,
    input  logic                   read,
    input  logic                   write,
    input  tlb_pkg::vtag_t         write_vtag,
    input  tlb_pkg::ptag_t         write_ptag,
    input  tlb_pkg::metadata_hi_t  write_meta,
    output tlb_pkg::tlb_way_read_t way_read
);

    localparam int SETS = 2 ** `TLB_ENTRIES_W;

    tlb_mem_1rw #(
        .WIDTH ($bits(tlb_pkg::vtag_t)),
        .DEPTH (SETS)
    ) u_vtag_mem (
        .clk       (clk),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (write_vtag),
        .readdata  (way_read.vtag)
    );

    tlb_mem_1rw #(
        .WIDTH ($bits(tlb_pkg::ptag_t)),
        .DEPTH (SETS)
    ) u_ptag_mem (
        .clk       (clk),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (write_ptag),
        .readdata  (way_read.ptag)
    );

    // Metadata bit 0 lives in the controller as the valid bit
    tlb_mem_1rw #(
        .WIDTH ($bits(tlb_pkg::metadata_hi_t)),
        .DEPTH (SETS)
    ) u_meta_mem (
        .clk       (clk),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (write_meta),
        .readdata  (way_read.meta_hi)
    );

endmodule

// File: source/tlb_control.sv
`include "tlb_defs.svh"

module tlb_control (
    input  logic                  clk,
    input  logic                  reset,
    input  tlb_pkg::tlb_request_t request,
    output logic                  mem_read,
    output logic [`TLB_WAYS-1:0]  way_write,
    output tlb_pkg::vtag_t        stage_vtag,
    output logic [`TLB_WAYS-1:0]  stage_valid,
    output logic                  resolve_done
);

    localparam int SETS = 2 ** `TLB_ENTRIES_W;
    localparam tlb_pkg::way_index_t LAST_WAY = tlb_pkg::way_index_t'(`TLB_WAYS - 1);

    tlb_pkg::set_index_t            req_index;
    tlb_pkg::vtag_t                 req_vtag;
    tlb_pkg::set_index_t            stage_index;
    tlb_pkg::way_index_t            victim;
    logic [`TLB_WAYS-1:0][SETS-1:0] valid;
    logic                           is_resolve;
    logic                           is_new_entry;
    logic                           is_invalidate;

    assign req_index = request.vpn[`TLB_ENTRIES_W-1:0];
    assign req_vtag  = request.vpn[`TLB_VPN_W-1:`TLB_ENTRIES_W];

    assign is_resolve    = (request.cmd == `TLB_CMD_RESOLVE);
    assign is_new_entry  = (request.cmd == `TLB_CMD_NEW_ENTRY);
    assign is_invalidate = (request.cmd == `TLB_CMD_INVALIDATE_ALL);

    assign mem_read = is_resolve;

    always_comb begin
        way_write = '0;
        if (is_new_entry) begin
            way_write[victim] = 1'b1; // Only the victim way is written
        end
    end

    // Valid bits and round-robin victim pointer
    always_ff @(posedge clk) begin
        if (reset || is_invalidate) begin
            valid  <= '0;
            victim <= '0;
        end else if (is_new_entry) begin
            valid[victim][req_index] <= request.new_metadata[0];
            victim <= (victim == LAST_WAY) ? '0 : victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (is_resolve) begin
            stage_vtag  <= req_vtag;
            stage_index <= req_index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_done <= 1'b0;
        end else begin
            resolve_done <= is_resolve;
        end
    end

    always_comb begin
        for (int w = 0; w < `TLB_WAYS; w++) begin
            stage_valid[w] = valid[w][stage_index]; // Reads the live valid bits
        end
    end

    victim_in_range: assert property (
        @(posedge clk) disable iff (reset) victim <= LAST_WAY
    );

    // Exactly one way on a new entry and none otherwise
    single_way_write: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(way_write) && ((way_write != '0) == is_new_entry)
    );

    // Result strobe high exactly one edge after each resolve
    done_after_resolve: assert property (
        @(posedge clk) disable iff (reset)
        resolve_done == $past(is_resolve && !reset)
    );

endmodule

// File: source/tlb_hit_select.sv
`include "tlb_defs.svh"

module tlb_hit_select (
    input  tlb_pkg::tlb_way_read_t [`TLB_WAYS-1:0] way_reads,
    input  tlb_pkg::vtag_t                         stage_vtag,
    input  logic [`TLB_WAYS-1:0]                   stage_valid,
    output tlb_pkg::tlb_result_t                   result
);

    logic [`TLB_WAYS-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < `TLB_WAYS; w++) begin
            way_hit[w] = stage_valid[w] && (way_reads[w].vtag == stage_vtag);
        end
    end

    // Later ways override earlier ones, so the highest hit wins
    always_comb begin
        result.hit      = 1'b0;
        result.way      = '0;
        result.ptag     = way_reads[0].ptag;     // Don't care on a miss
        result.metadata = {way_reads[0].meta_hi, stage_valid[0]};
        for (int w = 0; w < `TLB_WAYS; w++) begin
            if (way_hit[w]) begin
                result.hit      = 1'b1;
                result.way      = tlb_pkg::way_index_t'(w);
                result.ptag     = way_reads[w].ptag;
                result.metadata = {way_reads[w].meta_hi, stage_valid[w]};
            end
        end
    end

endmodule

// File: source/tlb.sv
`include "tlb_defs.svh"

module tlb (
    input  logic                  clk,
    input  logic                  reset,
    input  tlb_pkg::tlb_request_t request,
    output tlb_pkg::tlb_result_t  result,
    output logic                  resolve_done
);

    logic                                   mem_read;
    logic [`TLB_WAYS-1:0]                   way_write;
    tlb_pkg::vtag_t                         stage_vtag;
    logic [`TLB_WAYS-1:0]                   stage_valid;
    tlb_pkg::tlb_way_read_t [`TLB_WAYS-1:0] way_reads;

    tlb_control u_control (
        .clk          (clk),
        .reset        (reset),
        .request      (request),
        .mem_read     (mem_read),
        .way_write    (way_write),
        .stage_vtag   (stage_vtag),
        .stage_valid  (stage_valid),
        .resolve_done (resolve_done)
    );

    // All ways share address and write data, way_write picks the victim
    for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
        tlb_way_store u_way_store (
            .clk        (clk),
            .address    (request.vpn[`TLB_ENTRIES_W-1:0]),
            .read       (mem_read),
            .write      (way_write[w]),
            .write_vtag (request.vpn[`TLB_VPN_W-1:`TLB_ENTRIES_W]),
            .write_ptag (request.new_ptag),
            .write_meta (request.new_metadata[`TLB_META_W-1:1]),
            .way_read   (way_reads[w])
        );
    end

    tlb_hit_select u_hit_select (
        .way_reads   (way_reads),
        .stage_vtag  (stage_vtag),
        .stage_valid (stage_valid),
        .result      (result)
    );

endmodule

// File: test/tlb_tb.sv
`include "tlb_defs.svh"

module tlb_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int SETS = 2 ** `TLB_ENTRIES_W;
    localparam int NUM_COMMANDS = 3000;
    localparam int POOL_SIZE = 24;
    localparam int DONE_TIMEOUT = 4;
    localparam tlb_pkg::way_index_t LAST_WAY = tlb_pkg::way_index_t'(`TLB_WAYS - 1);

    logic                  clk;
    logic                  reset;
    tlb_pkg::tlb_request_t request;
    tlb_pkg::tlb_result_t  result;
    logic                  resolve_done;

    // Reference model state
    logic                 m_valid [`TLB_WAYS][SETS];
    tlb_pkg::vtag_t       m_vtag  [`TLB_WAYS][SETS];
    tlb_pkg::ptag_t       m_ptag  [`TLB_WAYS][SETS];
    tlb_pkg::metadata_t   m_meta  [`TLB_WAYS][SETS];
    tlb_pkg::way_index_t  m_victim;

    tlb_pkg::vpn_t        vpn_pool [POOL_SIZE];
    logic                 pending;
    logic                 exp_hit;
    tlb_pkg::way_index_t  exp_way;
    tlb_pkg::ptag_t       exp_ptag;
    tlb_pkg::metadata_t   exp_meta;

    tlb dut0 (
        .clk          (clk),
        .reset        (reset),
        .request      (request),
        .result       (result),
        .resolve_done (resolve_done)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_hit(input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: result.hit = %b, expected %b",
                               $time, actual, expected));
        end
    endtask

    task automatic check_way(input tlb_pkg::way_index_t actual,
                             input tlb_pkg::way_index_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: result.way = %0d, expected %0d",
                               $time, actual, expected));
        end
    endtask

    task automatic check_entry(input tlb_pkg::ptag_t actual_ptag,
                               input tlb_pkg::ptag_t expected_ptag,
                               input tlb_pkg::metadata_t actual_meta,
                               input tlb_pkg::metadata_t expected_meta);
        if (actual_ptag !== expected_ptag) begin
            stop_run($sformatf("FAILED at %0t: result.ptag = %h, expected %h",
                               $time, actual_ptag, expected_ptag));
        end
        if (actual_meta !== expected_meta) begin
            stop_run($sformatf("FAILED at %0t: result.metadata = %h, expected %h",
                               $time, actual_meta, expected_meta));
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: resolve_done = %b, expected %b",
                               $time, actual, expected));
        end
    endtask

    task automatic clear_model();
        for (int w = 0; w < `TLB_WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[w][s] = 1'b0;
            end
        end
        m_victim = '0;
    endtask

    task automatic drive_random_request();
        int unsigned pick;
        tlb_pkg::tlb_request_t req;
        pick = $urandom % 100;
        req.vpn = vpn_pool[$urandom % POOL_SIZE];
        req.new_ptag = tlb_pkg::ptag_t'($urandom);
        req.new_metadata = tlb_pkg::metadata_t'($urandom);
        req.new_metadata[0] = (($urandom % 100) < 85);
        if (pick < 45) begin
            req.cmd = `TLB_CMD_RESOLVE;
        end else if (pick < 80) begin
            req.cmd = `TLB_CMD_NEW_ENTRY;
        end else if (pick < 95) begin
            req.cmd = `TLB_CMD_NONE;
        end else begin
            req.cmd = `TLB_CMD_INVALIDATE_ALL;
        end
        request = req;
    endtask

    // Applies the command sampled at this rising edge
    task automatic update_model();
        tlb_pkg::set_index_t s;
        tlb_pkg::vtag_t vt;
        logic found;
        s = request.vpn[`TLB_ENTRIES_W-1:0];
        vt = request.vpn[`TLB_VPN_W-1:`TLB_ENTRIES_W];
        found = 1'b0;
        case (request.cmd)
            `TLB_CMD_RESOLVE: begin
                exp_hit = 1'b0;
                exp_way = '0;
                exp_ptag = '0;
                exp_meta = '0;
                for (int w = `TLB_WAYS - 1; w >= 0; w--) begin // Highest way first
                    if (!found && m_valid[w][s] && m_vtag[w][s] == vt) begin
                        found = 1'b1;
                        exp_hit = 1'b1;
                        exp_way = tlb_pkg::way_index_t'(w);
                        exp_ptag = m_ptag[w][s];
                        exp_meta = {m_meta[w][s][`TLB_META_W-1:1], 1'b1};
                    end
                end
                pending = 1'b1;
            end
            `TLB_CMD_NEW_ENTRY: begin
                m_vtag[m_victim][s] = vt;
                m_ptag[m_victim][s] = request.new_ptag;
                m_meta[m_victim][s] = request.new_metadata;
                m_valid[m_victim][s] = request.new_metadata[0];
                m_victim = (m_victim == LAST_WAY) ? '0 : m_victim + 1'b1;
            end
            `TLB_CMD_INVALIDATE_ALL: clear_model();
            default: ;
        endcase
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (resolve_done !== 1'b1) begin
            if (waited == DONE_TIMEOUT) begin
                stop_run("Timeout: resolve_done did not arrive after a resolve");
            end
            request.cmd = `TLB_CMD_NONE;
            @(negedge clk);
            waited++;
        end
    endtask

    // Mid-cycle, before the next command takes effect
    task automatic check_cycle();
        if (pending) begin
            wait_for_done();
            check_hit(result.hit, exp_hit);
            check_way(result.way, exp_way);
            if (exp_hit) begin
                check_entry(result.ptag, exp_ptag, result.metadata, exp_meta);
            end
            pending = 1'b0;
        end else begin
            check_strobe(resolve_done, 1'b0);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        request = '0;
        pending = 1'b0;
        exp_hit = 1'b0;
        exp_way = '0;
        exp_ptag = '0;
        exp_meta = '0;
        void'($urandom(32'h2fc1_1179));
        clear_model();

        // Few sets, several tags each, so conflicts and hits are common
        for (int i = 0; i < POOL_SIZE; i++) begin
            vpn_pool[i] = {tlb_pkg::vtag_t'($urandom),
                           tlb_pkg::set_index_t'((i % 6) * 3)};
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_COMMANDS; i++) begin
            drive_random_request();
            @(posedge clk);
            update_model();
            @(negedge clk);
            check_cycle();
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/tlb_pkg.sv
source/tlb_mem_1rw.sv
source/tlb_way_store.sv
source/tlb_control.sv
source/tlb_hit_select.sv
source/tlb.sv
test/tlb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TLB testbench with Verilator

verilator --binary --timing --assert --top-module tlb_tb -f filelist.f -o tlb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tlb_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log

grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
